//--- fe_arch_pkg.sv
// Architectural sizes of the fetch front end
// Address and instruction widths, instruction memory geometry
// and the sequential pc increment

package fe_arch_pkg;

  // Virtual address width of pcs and command addresses
  localparam int vaddr_width = 16;

  // Instruction and fill word width
  localparam int instr_width = 32;

  // Instruction memory depth in words and its word index width
  localparam int imem_words      = 64;
  localparam int imem_addr_width = 6;

  // Sequential fetch advances by one word
  localparam logic [vaddr_width-1:0] pc_step = vaddr_width'(4);

endpackage

//--- fe_msg_pkg.sv
// Message and control encodings of the fetch front end
// Command opcodes, fetch FSM states, queue message types
// and exception codes

package fe_msg_pkg;

  // Command port opcodes
  typedef enum logic [1:0]
  {
    e_op_state_reset = 2'd0,
    e_op_pc_redirect = 2'd1,
    e_op_imem_fill   = 2'd2,
    e_op_wait        = 2'd3
  } fe_cmd_op_e;

  // Controlling FSM states
  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  // Queue message kinds
  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  // Exception codes with misaligned taking priority
  typedef enum logic
  {
    e_instr_misaligned   = 1'b0,
    e_instr_access_fault = 1'b1
  } fe_exc_code_e;

endpackage

//--- fe_imem.sv
// Instruction memory of the fetch front end
// 64-word RAM with one write requester and one read requester
// Fixed-priority arbiter where a write always wins and a blocked read is dropped
// Granted reads return data on the following cycle

module fe_imem
  (input  logic                                    clk_i
   , input  logic                                  reset_i

   , input  logic                                  wr_v_i
   , input  logic [fe_arch_pkg::imem_addr_width-1:0] wr_addr_i
   , input  logic [fe_arch_pkg::instr_width-1:0]   wr_data_i

   , input  logic                                  rd_v_i
   , input  logic [fe_arch_pkg::imem_addr_width-1:0] rd_addr_i
   , output logic                                  rd_gnt_o
   , output logic [fe_arch_pkg::instr_width-1:0]   rd_data_o
   );

  logic [fe_arch_pkg::instr_width-1:0] mem_r [fe_arch_pkg::imem_words];
  logic wr_en;

  // Memory contents are left alone while held in reset
  assign wr_en = wr_v_i & ~reset_i;

  // Write over read
  assign rd_gnt_o = rd_v_i & ~wr_v_i;

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      mem_r[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_gnt_o)
    begin
      rd_data_o <= mem_r[rd_addr_i];
    end
  end

endmodule

//--- fe_ctrl.sv
// Command controller of the fetch front end
// Opcode decode and command acceptance
// Wait/run/stall FSM with redirect, resume and flush controls
// Fill write requester toward the instruction memory

module fe_ctrl
  (input  logic                                      clk_i
   , input  logic                                    reset_i

   , input  logic                                    fe_cmd_v_i
   , input  fe_msg_pkg::fe_cmd_op_e                  fe_cmd_opcode_i
   , input  logic [fe_arch_pkg::vaddr_width-1:0]     fe_cmd_vaddr_i
   , input  logic [fe_arch_pkg::instr_width-1:0]     fe_cmd_data_i
   , output logic                                    fe_cmd_yumi_o

   , input  logic                                    fe_queue_ready_i
   , input  logic                                    fetch_fail_i
   , input  logic                                    exception_sent_i

   , output logic                                    redirect_v_o
   , output logic [fe_arch_pkg::vaddr_width-1:0]     redirect_pc_o
   , output logic                                    resume_v_o
   , output logic                                    flush_o
   , output logic                                    fetch_en_o

   , output logic                                    fill_v_o
   , output logic [fe_arch_pkg::imem_addr_width-1:0] fill_addr_o
   , output logic [fe_arch_pkg::instr_width-1:0]     fill_data_o
   );

  fe_msg_pkg::fe_state_e state_r, state_n;
  logic cmd_v;
  logic state_reset_v, pc_redirect_v, fill_v, wait_v;
  logic cmd_immediate_v;
  logic unstall;

  // Every command is taken in the cycle it appears
  assign cmd_v         = fe_cmd_v_i & ~reset_i;
  assign fe_cmd_yumi_o = cmd_v;

  assign state_reset_v = cmd_v & (fe_cmd_opcode_i == fe_msg_pkg::e_op_state_reset);
  assign pc_redirect_v = cmd_v & (fe_cmd_opcode_i == fe_msg_pkg::e_op_pc_redirect);
  assign fill_v        = cmd_v & (fe_cmd_opcode_i == fe_msg_pkg::e_op_imem_fill);
  assign wait_v        = cmd_v & (fe_cmd_opcode_i == fe_msg_pkg::e_op_wait);

  assign cmd_immediate_v = state_reset_v | pc_redirect_v;

  assign redirect_v_o  = cmd_immediate_v;
  assign redirect_pc_o = fe_cmd_vaddr_i;

  // Any command kills what is in flight
  assign flush_o = cmd_v;

  // Fill vaddr is a byte address
  assign fill_v_o    = fill_v;
  assign fill_addr_o = fe_cmd_vaddr_i[fe_arch_pkg::imem_addr_width+1:2];
  assign fill_data_o = fe_cmd_data_i;

  assign unstall    = fe_queue_ready_i & ~cmd_v;
  assign resume_v_o = (state_r == fe_msg_pkg::e_stall) & unstall;
  assign fetch_en_o = (state_n == fe_msg_pkg::e_run);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      // Only a redirect or state reset leaves wait
      fe_msg_pkg::e_wait:
      begin
        if (cmd_immediate_v)
          state_n = fe_msg_pkg::e_run;
      end
      fe_msg_pkg::e_run:
      begin
        if (cmd_immediate_v)
          state_n = fe_msg_pkg::e_run;
        else if (wait_v)
          state_n = fe_msg_pkg::e_wait;
        else if (fill_v | fetch_fail_i)
          state_n = fe_msg_pkg::e_stall;
        else if (exception_sent_i)
          state_n = fe_msg_pkg::e_wait;
      end
      // Restart from the resume pc once the queue can take messages
      fe_msg_pkg::e_stall:
      begin
        if (cmd_immediate_v)
          state_n = fe_msg_pkg::e_run;
        else if (wait_v)
          state_n = fe_msg_pkg::e_wait;
        else if (unstall)
          state_n = fe_msg_pkg::e_run;
      end
      default:
        state_n = fe_msg_pkg::e_wait;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= fe_msg_pkg::e_wait;
    else
      state_r <= state_n;
  end

endmodule

//--- fe_fetch_pipe.sv
// Two-stage fetch pipeline of the front end
// Next pc and resume pc registers
// IF1/IF2 valid, pc and fault flag stages
// Misaligned and access fault detection
// Queue message formation and delivery status

module fe_fetch_pipe
  (input  logic                                      clk_i
   , input  logic                                    reset_i

   , input  logic                                    redirect_v_i
   , input  logic [fe_arch_pkg::vaddr_width-1:0]     redirect_pc_i
   , input  logic                                    resume_v_i
   , input  logic                                    flush_i
   , input  logic                                    fetch_en_i

   , output logic                                    rd_v_o
   , output logic [fe_arch_pkg::imem_addr_width-1:0] rd_addr_o
   , input  logic                                    rd_gnt_i
   , input  logic [fe_arch_pkg::instr_width-1:0]     rd_data_i

   , output logic                                    fetch_fail_o
   , output logic                                    exception_sent_o

   , input  logic                                    fe_queue_ready_i
   , output logic                                    fe_queue_v_o
   , output fe_msg_pkg::fe_msg_type_e                fe_queue_msg_type_o
   , output logic [fe_arch_pkg::vaddr_width-1:0]     fe_queue_pc_o
   , output logic [fe_arch_pkg::instr_width-1:0]     fe_queue_instr_o
   , output fe_msg_pkg::fe_exc_code_e                fe_queue_exc_code_o
   );

  logic [fe_arch_pkg::vaddr_width-1:0] pc_r, resume_pc_r;
  logic [fe_arch_pkg::vaddr_width-1:0] if1_pc_r, if2_pc_r;
  logic [fe_arch_pkg::instr_width-1:0] if2_instr_r;
  logic if1_v_r, if1_misaligned_r, if1_access_r;
  logic if2_v_r, if2_misaligned_r, if2_access_r;
  logic issue_v, advance;
  logic misaligned, access_fault, fault_v;
  logic exc_v, poison;

  // No issue in a cycle that loads a new pc
  assign issue_v = fetch_en_i & ~redirect_v_i & ~resume_v_i & ~flush_i;

  assign misaligned   = |pc_r[1:0];
  // Anything above the top word of the memory
  assign access_fault = |pc_r[fe_arch_pkg::vaddr_width-1:fe_arch_pkg::imem_addr_width+2];
  assign fault_v      = misaligned | access_fault;

  // Faulting pcs skip the memory but still enter IF1
  assign rd_v_o    = issue_v & ~fault_v;
  assign rd_addr_o = pc_r[fe_arch_pkg::imem_addr_width+1:2];
  assign advance   = issue_v & (fault_v | rd_gnt_i);

  assign exc_v            = if2_misaligned_r | if2_access_r;
  assign fe_queue_v_o     = if2_v_r & fe_queue_ready_i & ~flush_i;
  assign fetch_fail_o     = if2_v_r & ~fe_queue_v_o;
  assign exception_sent_o = fe_queue_v_o & exc_v;
  assign poison           = flush_i | fetch_fail_o | exception_sent_o;

  assign fe_queue_msg_type_o = exc_v ? fe_msg_pkg::e_fe_exception : fe_msg_pkg::e_fe_fetch;
  assign fe_queue_pc_o       = if2_pc_r;
  assign fe_queue_instr_o    = exc_v ? '0 : if2_instr_r;
  assign fe_queue_exc_code_o = if2_misaligned_r
                               ? fe_msg_pkg::e_instr_misaligned
                               : fe_msg_pkg::e_instr_access_fault;

  // An ungranted read leaves the pc where it is
  always_ff @(posedge clk_i)
  begin
    if (redirect_v_i)
      pc_r <= redirect_pc_i;
    else if (resume_v_i)
      pc_r <= resume_pc_r;
    else if (advance)
      pc_r <= pc_r + fe_arch_pkg::pc_step;
  end

  // Tracks the first pc not yet delivered
  always_ff @(posedge clk_i)
  begin
    if (redirect_v_i)
      resume_pc_r <= redirect_pc_i;
    else if (fe_queue_v_o)
      resume_pc_r <= if2_pc_r + fe_arch_pkg::pc_step;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      if1_v_r <= 1'b0;
      if2_v_r <= 1'b0;
    end
    else
    begin
      if1_v_r <= advance & ~poison;
      if2_v_r <= if1_v_r & ~poison;
    end
  end

  // Read data lands during IF1 and is captured with the IF2 stage
  always_ff @(posedge clk_i)
  begin
    if1_pc_r         <= pc_r;
    if1_misaligned_r <= misaligned;
    if1_access_r     <= access_fault;
    if2_pc_r         <= if1_pc_r;
    if2_misaligned_r <= if1_misaligned_r;
    if2_access_r     <= if1_access_r;
    if2_instr_r      <= rd_data_i;
  end

endmodule

//--- fe_top.sv
// Top level of the instruction fetch front end
// Command controller, fetch pipeline and instruction memory
// The controller writes and the pipeline reads the shared memory

module fe_top
  (input  logic                                  clk_i
   , input  logic                                reset_i

   , input  logic                                fe_cmd_v_i
   , input  fe_msg_pkg::fe_cmd_op_e              fe_cmd_opcode_i
   , input  logic [fe_arch_pkg::vaddr_width-1:0] fe_cmd_vaddr_i
   , input  logic [fe_arch_pkg::instr_width-1:0] fe_cmd_data_i
   , output logic                                fe_cmd_yumi_o

   , output logic                                fe_queue_v_o
   , output fe_msg_pkg::fe_msg_type_e            fe_queue_msg_type_o
   , output logic [fe_arch_pkg::vaddr_width-1:0] fe_queue_pc_o
   , output logic [fe_arch_pkg::instr_width-1:0] fe_queue_instr_o
   , output fe_msg_pkg::fe_exc_code_e            fe_queue_exc_code_o
   , input  logic                                fe_queue_ready_i
   );

  logic redirect_v, resume_v, flush, fetch_en;
  logic [fe_arch_pkg::vaddr_width-1:0] redirect_pc;
  logic fetch_fail, exception_sent;

  logic fill_v;
  logic [fe_arch_pkg::imem_addr_width-1:0] fill_addr;
  logic [fe_arch_pkg::instr_width-1:0] fill_data;

  logic rd_v, rd_gnt;
  logic [fe_arch_pkg::imem_addr_width-1:0] rd_addr;
  logic [fe_arch_pkg::instr_width-1:0] rd_data;

  fe_ctrl ctrl_i
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .fe_cmd_v_i(fe_cmd_v_i)
     , .fe_cmd_opcode_i(fe_cmd_opcode_i)
     , .fe_cmd_vaddr_i(fe_cmd_vaddr_i)
     , .fe_cmd_data_i(fe_cmd_data_i)
     , .fe_cmd_yumi_o(fe_cmd_yumi_o)
     , .fe_queue_ready_i(fe_queue_ready_i)
     , .fetch_fail_i(fetch_fail)
     , .exception_sent_i(exception_sent)
     , .redirect_v_o(redirect_v)
     , .redirect_pc_o(redirect_pc)
     , .resume_v_o(resume_v)
     , .flush_o(flush)
     , .fetch_en_o(fetch_en)
     , .fill_v_o(fill_v)
     , .fill_addr_o(fill_addr)
     , .fill_data_o(fill_data)
     );

  fe_fetch_pipe pipe_i
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .redirect_v_i(redirect_v)
     , .redirect_pc_i(redirect_pc)
     , .resume_v_i(resume_v)
     , .flush_i(flush)
     , .fetch_en_i(fetch_en)
     , .rd_v_o(rd_v)
     , .rd_addr_o(rd_addr)
     , .rd_gnt_i(rd_gnt)
     , .rd_data_i(rd_data)
     , .fetch_fail_o(fetch_fail)
     , .exception_sent_o(exception_sent)
     , .fe_queue_ready_i(fe_queue_ready_i)
     , .fe_queue_v_o(fe_queue_v_o)
     , .fe_queue_msg_type_o(fe_queue_msg_type_o)
     , .fe_queue_pc_o(fe_queue_pc_o)
     , .fe_queue_instr_o(fe_queue_instr_o)
     , .fe_queue_exc_code_o(fe_queue_exc_code_o)
     );

  fe_imem imem_i
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .wr_v_i(fill_v)
     , .wr_addr_i(fill_addr)
     , .wr_data_i(fill_data)
     , .rd_v_i(rd_v)
     , .rd_addr_i(rd_addr)
     , .rd_gnt_o(rd_gnt)
     , .rd_data_o(rd_data)
     );

endmodule

//--- tb_fe_top.sv
// Testbench for the fetch front end
// Command steps from a table with a ready pattern and a message count per step
// Queue model built from a local memory image and the last redirect target
// Watchdog sized from the table length

module tb_fe_top;
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [fe_arch_pkg::vaddr_width-1:0] addr_t;
  typedef logic [fe_arch_pkg::instr_width-1:0] word_t;

  localparam int n_steps    = 11;
  localparam int clk_period = 10;
  localparam addr_t imem_bytes = addr_t'(fe_arch_pkg::imem_words * 4);

  logic clk_i = 1'b0;
  logic reset_i;
  logic cmd_v, cmd_yumi, queue_v, queue_ready;
  fe_msg_pkg::fe_cmd_op_e cmd_op;
  fe_msg_pkg::fe_msg_type_e queue_type;
  fe_msg_pkg::fe_exc_code_e queue_code;
  addr_t cmd_vaddr, queue_pc, exp_pc;
  word_t cmd_data, queue_instr;

  string step_name [n_steps];
  fe_msg_pkg::fe_cmd_op_e step_op [n_steps];
  addr_t step_vaddr [n_steps];
  word_t step_data [n_steps];
  int step_words [n_steps];
  bit step_rand [n_steps];
  int step_msgs [n_steps];
  int step_quiet [n_steps];

  word_t image [fe_arch_pkg::imem_words];
  bit halted;
  int n_built, got, step_errors, errors, tests, failed;
  string cur_name;

  fe_top dut_i
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .fe_cmd_v_i(cmd_v)
     , .fe_cmd_opcode_i(cmd_op)
     , .fe_cmd_vaddr_i(cmd_vaddr)
     , .fe_cmd_data_i(cmd_data)
     , .fe_cmd_yumi_o(cmd_yumi)
     , .fe_queue_v_o(queue_v)
     , .fe_queue_msg_type_o(queue_type)
     , .fe_queue_pc_o(queue_pc)
     , .fe_queue_instr_o(queue_instr)
     , .fe_queue_exc_code_o(queue_code)
     , .fe_queue_ready_i(queue_ready)
     );

  always #(clk_period / 2) clk_i = ~clk_i;

  task automatic add_step(input string name, input fe_msg_pkg::fe_cmd_op_e op,
                          input addr_t vaddr, input word_t data, input int words,
                          input bit rnd, input int msgs, input int quiet);
    step_name[n_built]  = name;
    step_op[n_built]    = op;
    step_vaddr[n_built] = vaddr;
    step_data[n_built]  = data;
    step_words[n_built] = words;
    step_rand[n_built]  = rnd;
    step_msgs[n_built]  = msgs;
    step_quiet[n_built] = quiet;
    n_built++;
  endtask

  task automatic report_mismatch(input string what, input word_t exp_v, input word_t act_v);
    $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp_v, act_v);
    step_errors++;
  endtask

  // Expected message follows from the pc alone
  task automatic check_queue();
    bit exc;
    fe_msg_pkg::fe_msg_type_e exp_type;
    fe_msg_pkg::fe_exc_code_e exp_code;
    exc      = (exp_pc[1:0] != 2'b00) || (exp_pc >= imem_bytes);
    exp_type = exc ? fe_msg_pkg::e_fe_exception : fe_msg_pkg::e_fe_fetch;
    exp_code = (exp_pc[1:0] != 2'b00) ? fe_msg_pkg::e_instr_misaligned
                                      : fe_msg_pkg::e_instr_access_fault;
    if (queue_v && halted)
    begin
      $display("Unexpected message at pc %h in %s after the stream stopped", queue_pc, cur_name);
      step_errors++;
    end
    else if (queue_v)
    begin
      if (queue_pc !== exp_pc)
        report_mismatch("pc", word_t'(exp_pc), word_t'(queue_pc));
      if (queue_type !== exp_type)
        report_mismatch("type", word_t'(exp_type), word_t'(queue_type));
      if (exc && queue_code !== exp_code)
        report_mismatch("code", word_t'(exp_code), word_t'(queue_code));
      if (exc && queue_instr !== '0)
        report_mismatch("instr", '0, queue_instr);
      if (!exc && queue_instr !== image[exp_pc[fe_arch_pkg::imem_addr_width+1:2]])
        report_mismatch("instr", image[exp_pc[fe_arch_pkg::imem_addr_width+1:2]], queue_instr);
      got++;
      exp_pc = exp_pc + fe_arch_pkg::pc_step;
      halted = exc;
    end
  endtask

  task automatic run_cycle(input bit v, input fe_msg_pkg::fe_cmd_op_e op,
                           input addr_t va, input word_t d, input bit rnd);
    @(posedge clk_i);
    cmd_v       <= v;
    cmd_op      <= op;
    cmd_vaddr   <= va;
    cmd_data    <= d;
    queue_ready <= rnd ? ($urandom_range(1, 0) != 0) : 1'b1;
    @(negedge clk_i);
    if (v && !cmd_yumi)
    begin
      $display("Command not taken in %s", cur_name);
      step_errors++;
    end
    if (v && queue_v)
    begin
      $display("Message delivered during a command cycle in %s", cur_name);
      step_errors++;
    end
    if (!v)
      check_queue();
  endtask

  task automatic finish_test();
    if (step_errors == 0)
      $display("%s: passed, %0d messages", cur_name, got);
    else
      $display("%s: failed with %0d errors", cur_name, step_errors);
    tests++;
    errors += step_errors;
    if (step_errors != 0)
      failed++;
  endtask

  initial
  begin
    addr_t addr;
    word_t data;
    void'($urandom(64737));
    reset_i     = 1'b1;
    cmd_v       = 1'b0;
    cmd_op      = fe_msg_pkg::e_op_wait;
    cmd_vaddr   = '0;
    cmd_data    = '0;
    queue_ready = 1'b1;
    exp_pc      = '0;
    halted      = 1'b1;
    n_built     = 0;
    errors      = 0;
    tests       = 0;
    failed      = 0;

    // name, opcode, vaddr, data, words, random ready, messages, quiet cycles
    add_step("fill_image", fe_msg_pkg::e_op_imem_fill, 16'h0000, 32'h5a5a_0000, 64, 1'b0, 0, 0);
    add_step("fetch_seq", fe_msg_pkg::e_op_pc_redirect, 16'h0000, '0, 1, 1'b0, 16, 0);
    add_step("backpressure", fe_msg_pkg::e_op_pc_redirect, 16'h0040, '0, 1, 1'b1, 24, 0);
    add_step("redirect_mid", fe_msg_pkg::e_op_pc_redirect, 16'h0010, '0, 1, 1'b1, 6, 0);
    add_step("fill_mid", fe_msg_pkg::e_op_imem_fill, 16'h0030, 32'hc3c3_0000, 2, 1'b0, 8, 0);
    add_step("wait_stop", fe_msg_pkg::e_op_wait, 16'h0000, '0, 1, 1'b0, 0, 20);
    add_step("restart", fe_msg_pkg::e_op_pc_redirect, 16'h0080, '0, 1, 1'b0, 4, 0);
    add_step("misaligned", fe_msg_pkg::e_op_pc_redirect, 16'h0002, '0, 1, 1'b0, 1, 20);
    add_step("access_fault", fe_msg_pkg::e_op_pc_redirect, 16'h00f0, '0, 1, 1'b1, 5, 20);
    add_step("state_reset", fe_msg_pkg::e_op_state_reset, 16'h0020, '0, 1, 1'b0, 4, 0);
    add_step("fault_priority", fe_msg_pkg::e_op_pc_redirect, 16'h0102, '0, 1, 1'b0, 1, 20);

    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;

    cur_name    = "reset_idle";
    step_errors = 0;
    got         = 0;
    repeat (20) run_cycle(1'b0, fe_msg_pkg::e_op_wait, '0, '0, 1'b0);
    finish_test();

    for (int s = 0; s < n_steps; s++)
    begin
      cur_name    = step_name[s];
      step_errors = 0;
      got         = 0;
      for (int w = 0; w < step_words[s]; w++)
      begin
        addr = step_vaddr[s] + addr_t'(4 * w);
        data = step_data[s] ^ word_t'(addr);
        run_cycle(1'b1, step_op[s], addr, data, step_rand[s]);
        if (step_op[s] == fe_msg_pkg::e_op_imem_fill)
          image[addr[fe_arch_pkg::imem_addr_width+1:2]] = data;
        else if (step_op[s] == fe_msg_pkg::e_op_wait)
          halted = 1'b1;
        else
        begin
          exp_pc = addr;
          halted = 1'b0;
        end
      end
      while (got < step_msgs[s])
        run_cycle(1'b0, fe_msg_pkg::e_op_wait, '0, '0, step_rand[s]);
      repeat (step_quiet[s]) run_cycle(1'b0, fe_msg_pkg::e_op_wait, '0, '0, 1'b0);
      finish_test();
    end

    $display("Tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(n_steps * 200 * clk_period);
    $display("Timeout: %s did not finish within the cycle budget", cur_name);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- all.f
fe_arch_pkg.sv
fe_msg_pkg.sv
fe_imem.sv
fe_ctrl.sv
fe_fetch_pipe.sv
fe_top.sv
tb_fe_top.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --timescale 1ns/1ps
TOP   = tb_fe_top
FLIST = all.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
